// ==== rtl/alu16.sv ====
// 16-bit arithmetic unit of the execution path
// Add, subtract, logic, single shifts and signed compare
// Purely combinational
// Flag outputs feed R0

`timescale 1ns/1ps

module alu16 import mera_pkg::*; (
	input  op_t               op_q,
	input  logic [0:WORD_W-1] a_q,
	input  logic [0:WORD_W-1] b_q,
	output logic [0:WORD_W-1] res,
	output logic              zs,
	output logic              s_1,
	output logic              ovf,
	output logic              carry,
	output logic              lt,
	output logic              eq,
	output logic              gt,
	output logic              y_out,
	output logic              x_out
);

	// SUB adds the inverted operand plus one
	logic              is_sub;
	logic [0:WORD_W-1] b_eff;
	logic [WORD_W:0]   sum;

	assign is_sub = (op_q == OP_SUB);
	assign b_eff  = is_sub ? ~b_q : b_q;
	assign sum    = {1'b0, a_q} + {1'b0, b_eff} + {{WORD_W{1'b0}}, is_sub};

	// Carry out of the 17-bit sum
	assign carry = sum[WORD_W];

	// Same operand signs but a different sum sign
	assign ovf = (a_q[0] == b_eff[0]) && (sum[WORD_W-1] != a_q[0]);

	// Signed compare of a against b
	assign lt = $signed(a_q) < $signed(b_q);
	assign eq = (a_q == b_q);
	assign gt = $signed(a_q) > $signed(b_q);

	// Bits leaving the word on a shift
	// Bit 0 is the MSB
	assign y_out = a_q[0];
	assign x_out = a_q[WORD_W-1];

	always_comb begin
		case (op_q)
			OP_ADD,
			OP_SUB:  res = sum[WORD_W-1:0];
			OP_AND:  res = a_q & b_q;
			OP_OR:   res = a_q | b_q;
			OP_XOR:  res = a_q ^ b_q;
			// Compare passes a through
			OP_CMP:  res = a_q;
			OP_SHL:  res = a_q << 1;
			OP_SHR:  res = a_q >> 1;
			OP_LDR:  res = a_q;
			default: res = '0;
		endcase
	end

	// Zero and sign of the result
	assign zs  = (res == '0);
	assign s_1 = res[0];

endmodule

// ==== rtl/exec_control.sv ====
// Execution control FSM
// Latches operation and operands on start, runs the phase timer,
// decodes which R0 flags the operation updates
// and qualifies all update strobes with strob1

`timescale 1ns/1ps

module exec_control import mera_pkg::*; (
	input  logic              clk0,
	input  logic              reset4,
	input  logic              start,
	input  op_t               op,
	input  logic [0:WORD_W-1] a_op,
	input  logic [0:WORD_W-1] b_op,
	input  logic              strob1,
	input  logic              last,
	output op_t               op_q,
	output logic [0:WORD_W-1] a_q,
	output logic [0:WORD_W-1] b_q,
	output logic              timer_start,
	output flag_en_t          flag_en,
	output logic              load_word,
	output logic              clear,
	output logic              busy,
	output logic              done
);

	typedef enum logic [1:0] {
		IDLE   = 2'd0,
		RUN    = 2'd1,
		FINISH = 2'd2
	} state_t;

	state_t state;
	state_t state_nx;
	logic   accept;

	// Start accepted whenever not in RUN
	assign accept = start && (state != RUN);

	always_comb begin
		state_nx = state;
		case (state)
			IDLE:    if (accept) state_nx = RUN;
			RUN:     if (last) state_nx = FINISH;
			FINISH:  state_nx = accept ? RUN : IDLE;
			default: state_nx = IDLE;
		endcase
	end

	always_ff @(posedge clk0 or negedge reset4) begin
		if (!reset4) begin
			state       <= IDLE;
			op_q        <= OP_NOP;
			timer_start <= 1'b0;
		end else begin
			state       <= state_nx;
			timer_start <= accept;
			if (accept) begin
				op_q <= op;
			end
		end
	end

	// Operand latches
	always_ff @(posedge clk0) begin
		if (accept) begin
			a_q <= a_op;
			b_q <= b_op;
		end
	end

	assign busy = (state == RUN);
	assign done = (state == FINISH);

	// Raw decode of the latched operation
	flag_en_t upd;
	logic     ld_dec;
	logic     clr_dec;

	always_comb begin
		upd     = '0;
		ld_dec  = 1'b0;
		clr_dec = 1'b0;
		case (op_q)
			OP_ADD, OP_SUB: begin
				upd[FLAG_Z] = 1'b1;
				upd[FLAG_M] = 1'b1;
				upd[FLAG_V] = 1'b1;
				upd[FLAG_C] = 1'b1;
			end
			OP_AND, OP_OR, OP_XOR: begin
				upd[FLAG_Z] = 1'b1;
				upd[FLAG_M] = 1'b1;
			end
			OP_CMP: begin
				upd[FLAG_L] = 1'b1;
				upd[FLAG_E] = 1'b1;
				upd[FLAG_G] = 1'b1;
			end
			OP_SHL: begin
				upd[FLAG_Z] = 1'b1;
				upd[FLAG_M] = 1'b1;
				upd[FLAG_Y] = 1'b1;
			end
			OP_SHR: begin
				upd[FLAG_Z] = 1'b1;
				upd[FLAG_M] = 1'b1;
				upd[FLAG_X] = 1'b1;
			end
			OP_LDR:  ld_dec = 1'b1;
			OP_CLR:  clr_dec = 1'b1;
			default: ;
		endcase
	end

	// One-cycle update pulses in the strobe phase
	assign flag_en   = upd & {9{strob1}};
	assign load_word = ld_dec & strob1;
	assign clear     = clr_dec & strob1;

	a_done_pulse: assert property (
		@(posedge clk0) disable iff (!reset4)
		done |=> !done
	) else $error("exec_control: done longer than one cycle");

	a_done_after_busy: assert property (
		@(posedge clk0) disable iff (!reset4)
		done |-> $past(busy)
	) else $error("exec_control: done without preceding busy");

endmodule

// ==== rtl/exec_unit.sv ====
// MERA-400 condition-flag execution unit
// Control FSM, phase timer, 16-bit ALU and the R0 flag register

`timescale 1ns/1ps

module exec_unit import mera_pkg::*; (
	input  logic              clk0,
	input  logic              reset4,
	input  logic              start,
	input  op_t               op,
	input  logic [0:WORD_W-1] a_op,
	input  logic [0:WORD_W-1] b_op,
	output logic [0:WORD_W-1] result,
	output logic [0:WORD_W-1] r0,
	output logic              busy,
	output logic              done
);

	// Latched operation and operands
	op_t               op_q;
	logic [0:WORD_W-1] a_q;
	logic [0:WORD_W-1] b_q;

	// Timer links
	logic       timer_start;
	logic       strob1;
	logic       last;

	// ALU outputs
	logic [0:WORD_W-1] res;
	logic              zs;
	logic              s_1;
	logic              ovf;
	logic              carry;
	logic              lt;
	logic              eq;
	logic              gt;
	logic              y_out;
	logic              x_out;

	// R0 update strobes
	flag_en_t flag_en;
	logic     load_word;
	logic     clear;

	exec_control u_ctrl (
		.clk0(clk0), .reset4(reset4), .start(start), .op(op),
		.a_op(a_op), .b_op(b_op), .strob1(strob1), .last(last),
		.op_q(op_q), .a_q(a_q), .b_q(b_q), .timer_start(timer_start),
		.flag_en(flag_en), .load_word(load_word), .clear(clear),
		.busy(busy), .done(done)
	);

	phase_timer u_timer (
		.clk0(clk0), .reset4(reset4), .timer_start(timer_start),
		.phase(), .strob1(strob1), .last(last)
	);

	alu16 u_alu (
		.op_q(op_q), .a_q(a_q), .b_q(b_q), .res(res),
		.zs(zs), .s_1(s_1), .ovf(ovf), .carry(carry),
		.lt(lt), .eq(eq), .gt(gt), .y_out(y_out), .x_out(x_out)
	);

	flag_register u_r0 (
		.clk0(clk0), .reset4(reset4),
		.zs(zs), .s_1(s_1), .ovf(ovf), .carry(carry),
		.lt(lt), .eq(eq), .gt(gt), .y_out(y_out), .x_out(x_out),
		.flag_en(flag_en), .load_word(load_word), .clear(clear),
		.w(a_q), .r0(r0)
	);

	// Result follows the latched operands until the next start
	assign result = res;

endmodule

// ==== rtl/flag_register.sv ====
// R0 register of the MERA-400 processor
// Nine condition flags Z M V C L E G Y X in bits 0..8
// and seven user bits 9..15
// Flags update individually from the ALU under per-flag enables,
// the whole word loads from w, and clear zeroes it

`timescale 1ns/1ps

module flag_register import mera_pkg::*; (
	input  logic              clk0,
	input  logic              reset4,
	// ALU flag inputs
	input  logic              zs,
	input  logic              s_1,
	input  logic              ovf,
	input  logic              carry,
	input  logic              lt,
	input  logic              eq,
	input  logic              gt,
	input  logic              y_out,
	input  logic              x_out,
	// Update strobes, already qualified by strob1
	input  flag_en_t          flag_en,
	input  logic              load_word,
	input  logic              clear,
	// Load value
	input  logic [0:WORD_W-1] w,
	output logic [0:WORD_W-1] r0
);

	// Stored word, all flags kept in true polarity
	r0_word_u r0_q;

	// New flag values gathered in R0 bit order
	logic [0:8] flag_in;

	always_comb begin
		flag_in         = '0;
		flag_in[FLAG_Z] = zs;
		flag_in[FLAG_M] = s_1;
		flag_in[FLAG_V] = ovf;
		flag_in[FLAG_C] = carry;
		// Compare outcomes in true polarity
		flag_in[FLAG_L] = lt;
		flag_in[FLAG_E] = eq;
		flag_in[FLAG_G] = gt;
		flag_in[FLAG_Y] = y_out;
		flag_in[FLAG_X] = x_out;
	end

	// Priority: clear, then word load, then single flags
	always_ff @(posedge clk0 or negedge reset4) begin
		if (!reset4) begin
			r0_q.raw <= '0;
		end else if (clear) begin
			r0_q.raw <= '0;
		end else if (load_word) begin
			// LDR writes the word raw, user bits included
			r0_q.raw <= w;
		end else begin
			for (int i = 0; i < 9; i++) begin
				if (flag_en[i]) begin
					r0_q.fields.flags[i] <= flag_in[i];
				end
			end
			// User bits untouched here
		end
	end

	assign r0 = r0_q.raw;

	// Control decodes one operation at a time
	// so at most one kind of update strobe is live
	a_single_update: assert property (
		@(posedge clk0) disable iff (!reset4)
		$onehot0({load_word, clear, |flag_en})
	) else $error("flag_register: load_word, clear and flag enables overlap");

endmodule

// ==== rtl/mera_pkg.sv ====
// MERA-400 execution unit shared definitions
// Operation codes, timer phase constants, R0 flag positions
// and the R0 word with its raw and flag/user views
// Bit 0 is the most significant bit throughout

package mera_pkg;

	// Data word width
	localparam int WORD_W = 16;

	// Operation codes as presented on the op input
	typedef enum logic [3:0] {
		OP_ADD = 4'd0,
		OP_SUB = 4'd1,
		OP_AND = 4'd2,
		OP_OR  = 4'd3,
		OP_XOR = 4'd4,
		OP_CMP = 4'd5,
		OP_SHL = 4'd6,
		OP_SHR = 4'd7,
		OP_LDR = 4'd8,
		OP_CLR = 4'd9,
		OP_NOP = 4'd15
	} op_t;

	// Execute phases per operation and the phase carrying strob1
	localparam logic [1:0] EXEC_PHASES  = 2'd3;
	localparam logic [1:0] STROBE_PHASE = 2'd2;

	// Flag positions within R0, MSB first
	localparam logic [3:0] FLAG_Z = 4'd0;
	localparam logic [3:0] FLAG_M = 4'd1;
	localparam logic [3:0] FLAG_V = 4'd2;
	localparam logic [3:0] FLAG_C = 4'd3;
	localparam logic [3:0] FLAG_L = 4'd4;
	localparam logic [3:0] FLAG_E = 4'd5;
	localparam logic [3:0] FLAG_G = 4'd6;
	localparam logic [3:0] FLAG_Y = 4'd7;
	localparam logic [3:0] FLAG_X = 4'd8;

	// Flag half and user half of R0
	typedef struct packed {
		logic [0:8] flags;
		logic [0:6] user;
	} r0_fields_t;

	// R0 seen as one raw word (LDR, CLR) or as flags plus user bits
	typedef union packed {
		logic [0:WORD_W-1] raw;
		r0_fields_t        fields;
	} r0_word_u;

	// Per-flag update enables, same order as the flags
	typedef logic [0:8] flag_en_t;

endpackage

// ==== rtl/phase_timer.sv ====
// Execute phase timer
// Counts down through the execute phases after timer_start
// and produces strob1 and the final-phase pulse

`timescale 1ns/1ps

module phase_timer import mera_pkg::*; (
	input  logic       clk0,
	input  logic       reset4,
	input  logic       timer_start,
	output logic [1:0] phase,
	output logic       strob1,
	output logic       last
);

	// Remaining phases after the current one
	logic [1:0] cnt;
	logic       run;

	always_ff @(posedge clk0 or negedge reset4) begin
		if (!reset4) begin
			run <= 1'b0;
			cnt <= '0;
		end else if (timer_start) begin
			run <= 1'b1;
			cnt <= EXEC_PHASES - 2'd1;
		end else if (run) begin
			if (cnt == '0) begin
				run <= 1'b0;
			end else begin
				cnt <= cnt - 2'd1;
			end
		end
	end

	// Phase counts up as cnt counts down, parked at 0 when idle
	assign phase  = run ? (EXEC_PHASES - 2'd1 - cnt) : 2'd0;
	assign strob1 = run && (phase == STROBE_PHASE);
	assign last   = run && (cnt == '0);

	a_phase_range: assert property (
		@(posedge clk0) disable iff (!reset4)
		phase < EXEC_PHASES
	) else $error("phase_timer: phase out of range");

endmodule

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the execution unit testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f sources.f --top-module tb_exec_unit -Mdir obj_dir
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/Vtb_exec_unit > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "Simulation finished: FAIL" "$LOG"; then
	exit 1
fi
if ! grep -q "Simulation finished: PASS" "$LOG"; then
	echo "No final status found in $LOG"
	exit 1
fi
exit 0

// ==== sources.f ====
+incdir+test
rtl/mera_pkg.sv
rtl/flag_register.sv
rtl/alu16.sv
rtl/phase_timer.sv
rtl/exec_control.sv
rtl/exec_unit.sv
test/tb_exec_unit.sv

// ==== test/flag_model.svh ====
// Reference model of the execution unit
// Gives the expected ALU result and the next R0 word for one operation
// Operands use plain [15:0] words here, bit 15 being R0 bit 0 (MSB)

`ifndef FLAG_MODEL_SVH
`define FLAG_MODEL_SVH

// Result word of one operation
function automatic logic [15:0] expected_result(op_t o, logic [15:0] a, logic [15:0] b);
	case (o)
		OP_ADD:  return a + b;
		OP_SUB:  return a - b;
		OP_AND:  return a & b;
		OP_OR:   return a | b;
		OP_XOR:  return a ^ b;
		// Compare and load pass a through
		OP_CMP,
		OP_LDR:  return a;
		OP_SHL:  return {a[14:0], 1'b0};
		OP_SHR:  return {1'b0, a[15:1]};
		default: return 16'h0000;
	endcase
endfunction

// R0 after one operation, starting from old
function automatic logic [0:15] next_r0(op_t o, logic [15:0] a, logic [15:0] b,
		logic [0:15] old);
	logic [0:15]        nx;
	logic [15:0]        res;
	logic [16:0]        usum;
	logic signed [16:0] ssum;
	nx   = old;
	res  = expected_result(o, a, b);
	usum = {1'b0, a} + {1'b0, b};
	// Sign-extended sum or difference
	ssum = (o == OP_SUB) ? ({a[15], a} - {b[15], b}) : ({a[15], a} + {b[15], b});
	// Zero and sign for everything that produces a value
	if (o inside {OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_SHL, OP_SHR}) begin
		nx[FLAG_Z] = (res == 16'h0000);
		nx[FLAG_M] = res[15];
	end
	case (o)
		OP_CLR: nx = 16'h0000;
		OP_LDR: nx = a;
		OP_ADD, OP_SUB: begin
			// Overflow when the top two bits differ
			nx[FLAG_V] = ssum[16] ^ ssum[15];
			// Subtract carries out when there is no borrow
			nx[FLAG_C] = (o == OP_ADD) ? usum[16] : (a >= b);
		end
		OP_CMP: begin
			nx[FLAG_L] = $signed(a) < $signed(b);
			nx[FLAG_E] = (a == b);
			nx[FLAG_G] = $signed(a) > $signed(b);
		end
		OP_SHL:  nx[FLAG_Y] = a[15];
		OP_SHR:  nx[FLAG_X] = a[0];
		default: ;
	endcase
	return nx;
endfunction

`endif

// ==== test/tb_exec_unit.sv ====
// Testbench for the MERA-400 condition-flag execution unit
// Directed and random operations, checked by assertions at done
// against the reference model, with a cycle limit and a summary

`timescale 1ns/1ps

module tb_exec_unit import mera_pkg::*; ();

	`include "flag_model.svh"

	localparam int RESET_CYCLES   = 10;
	localparam int NUM_DIRECTED   = 20;
	localparam int NUM_RANDOM     = 200;
	localparam int TIMEOUT_CYCLES = (NUM_DIRECTED + NUM_RANDOM) * 30 + RESET_CYCLES;

	logic              clk0;
	logic              reset4;
	logic              start;
	op_t               op;
	logic [0:WORD_W-1] a_op;
	logic [0:WORD_W-1] b_op;
	logic [0:WORD_W-1] result;
	logic [0:WORD_W-1] r0;
	logic              busy;
	logic              done;

	// Expected values of the operation in flight
	op_t               exp_op;
	logic [0:WORD_W-1] exp_result;
	logic [0:WORD_W-1] exp_r0;

	int     errors;
	int     cycles;
	int     ops_done;
	integer seed;

	exec_unit UUT (
		.clk0(clk0), .reset4(reset4), .start(start), .op(op),
		.a_op(a_op), .b_op(b_op), .result(result), .r0(r0),
		.busy(busy), .done(done)
	);

	initial clk0 = 1'b0;
	always #20 clk0 = ~clk0;

	// Run limit
	always @(posedge clk0) begin
		cycles <= cycles + 1;
		if (cycles >= TIMEOUT_CYCLES) begin
			$display("Timeout: the run did not complete within %0d cycles",
				TIMEOUT_CYCLES);
			$display("Simulation finished: FAIL");
			$finish;
		end
	end

	// Accepted start gives four busy cycles, then done with busy low
	a_done_timing: assert property (@(posedge clk0) disable iff (!reset4)
		(start && !busy) |=> busy ##1 busy ##1 busy ##1 busy ##1 (done && !busy))
	else begin
		errors = errors + 1;
		$display("Error: time %0t: done not 5 cycles after accepted start", $time);
	end

	a_done_single: assert property (@(posedge clk0) disable iff (!reset4)
		done |=> !done)
	else begin
		errors = errors + 1;
		$display("Error: time %0t: done held longer than one cycle", $time);
	end

	// Ignored start must not disturb the latched operands
	a_ignored_start: assert property (@(posedge clk0) disable iff (!reset4)
		(start && busy) |=> $stable(result))
	else begin
		errors = errors + 1;
		$display("Error: time %0t: start during busy changed result", $time);
	end

	a_result: assert property (@(posedge clk0) disable iff (!reset4)
		done |-> (result == exp_result))
	else begin
		errors = errors + 1;
		$display("Error: time %0t: %s result %h, expected %h",
			$time, exp_op.name(), result, exp_result);
	end

	a_r0: assert property (@(posedge clk0) disable iff (!reset4)
		done |-> (r0 == exp_r0))
	else begin
		errors = errors + 1;
		$display("Error: time %0t: %s r0 %h, expected %h",
			$time, exp_op.name(), r0, exp_r0);
	end

	// Exactly one compare outcome
	a_cmp_onehot: assert property (@(posedge clk0) disable iff (!reset4)
		(done && exp_op == OP_CMP) |-> $onehot({r0[FLAG_L], r0[FLAG_E], r0[FLAG_G]}))
	else begin
		errors = errors + 1;
		$display("Error: time %0t: CMP left L E G not one-hot, r0 %h", $time, r0);
	end

	// Returns 2 ns after the edge that closes the done cycle
	task automatic wait_for_done();
		while (!done) begin
			@(posedge clk0);
			#2;
		end
		@(posedge clk0);
		#2;
	endtask

	task automatic issue_op(input op_t o, input logic [15:0] a, input logic [15:0] b);
		exp_op     = o;
		exp_result = expected_result(o, a, b);
		exp_r0     = next_r0(o, a, b, exp_r0);
		op    = o;
		a_op  = a;
		b_op  = b;
		start = 1'b1;
		@(posedge clk0);
		#2;
		start = 1'b0;
		wait_for_done();
		ops_done = ops_done + 1;
	endtask

	// Second start lands while busy and must be dropped
	task automatic busy_start_op(input op_t o, input logic [15:0] a, input logic [15:0] b,
			input op_t o2, input logic [15:0] a2, input logic [15:0] b2);
		exp_op     = o;
		exp_result = expected_result(o, a, b);
		exp_r0     = next_r0(o, a, b, exp_r0);
		op    = o;
		a_op  = a;
		b_op  = b;
		start = 1'b1;
		@(posedge clk0);
		#2;
		start = 1'b0;
		@(posedge clk0);
		#2;
		op    = o2;
		a_op  = a2;
		b_op  = b2;
		start = 1'b1;
		@(posedge clk0);
		#2;
		start = 1'b0;
		wait_for_done();
		ops_done = ops_done + 1;
	endtask

	function automatic op_t pick_op(int k);
		case (k)
			0:       return OP_ADD;
			1:       return OP_SUB;
			2:       return OP_AND;
			3:       return OP_OR;
			4:       return OP_XOR;
			5:       return OP_CMP;
			6:       return OP_SHL;
			7:       return OP_SHR;
			8:       return OP_LDR;
			default: return OP_CLR;
		endcase
	endfunction

	initial begin
		logic [31:0] rnd;
		op_t         o;
		logic [15:0] a;
		logic [15:0] b;
		seed     = 32'h62762dbb;
		errors   = 0;
		cycles   = 0;
		ops_done = 0;
		exp_op     = OP_NOP;
		exp_result = '0;
		exp_r0     = '0;
		reset4 = 1'b0;
		start  = 1'b0;
		op     = OP_NOP;
		a_op   = '0;
		b_op   = '0;
		repeat (RESET_CYCLES) @(posedge clk0);
		#2;
		reset4 = 1'b1;
		@(posedge clk0);
		#2;
		assert (r0 == 16'h0000 && !busy && !done) else begin
			errors = errors + 1;
			$display("Error: time %0t: r0=%h busy=%b done=%b after reset",
				$time, r0, busy, done);
		end

		// Directed cases
		issue_op(OP_CLR, 16'h0000, 16'h0000);
		issue_op(OP_LDR, 16'hFFFF, 16'h0000);
		issue_op(OP_ADD, 16'h7FFF, 16'h0001);
		issue_op(OP_ADD, 16'hFFFF, 16'h0001);
		issue_op(OP_SUB, 16'h0001, 16'h0002);
		issue_op(OP_SUB, 16'h8000, 16'h0001);
		issue_op(OP_CMP, 16'h8000, 16'h0001);
		issue_op(OP_CMP, 16'h1234, 16'h1234);
		issue_op(OP_CMP, 16'h0001, 16'hFFFF);
		issue_op(OP_SHL, 16'h8001, 16'h0000);
		issue_op(OP_SHL, 16'h4000, 16'h0000);
		issue_op(OP_SHR, 16'h0001, 16'h0000);
		issue_op(OP_SHR, 16'h8000, 16'h0000);
		issue_op(OP_AND, 16'hF0F0, 16'h0FF0);
		issue_op(OP_OR,  16'h0000, 16'h0000);
		issue_op(OP_XOR, 16'hAAAA, 16'h5555);
		issue_op(OP_LDR, 16'hA5C3, 16'h0000);
		issue_op(OP_NOP, 16'h1111, 16'h2222);
		busy_start_op(OP_ADD, 16'h1234, 16'h4321, OP_CLR, 16'hFFFF, 16'hFFFF);
		issue_op(OP_CLR, 16'h0000, 16'h0000);

		// Random operations, some with equal operands for CMP
		for (int i = 0; i < NUM_RANDOM; i++) begin
			rnd = $random(seed);
			o   = pick_op(int'(rnd % 32'd10));
			rnd = $random(seed);
			a   = rnd[15:0];
			b   = rnd[31:16];
			rnd = $random(seed);
			if (rnd[2:0] == 3'd0) begin
				b = a;
			end
			if (i % 40 == 39) begin
				busy_start_op(o, a, b, OP_XOR, ~a, ~b);
			end else begin
				issue_op(o, a, b);
			end
		end

		@(posedge clk0);
		#2;
		$display("Summary: %0d operations, %0d errors", ops_done, errors);
		if (errors == 0) begin
			$display("Simulation finished: PASS");
		end else begin
			$display("Simulation finished: FAIL");
		end
		$finish;
	end

endmodule
